// File: source/pkt_tx_pkg.sv
package pkt_tx_pkg;

   // ----------------------------------------
   // widths and payload beat
   // ----------------------------------------
   localparam int CMD_COUNT_W = 16;              // command byte count input
   localparam int DATA_TYPE_W = 6;               // packet data type field
   localparam int BYTE_CNT_W  = 14;              // remaining byte counter

   typedef logic [BYTE_CNT_W-1:0] byte_cnt_t;

   localparam byte_cnt_t BEAT_BYTES = 4;         // bytes per payload strobe

   // ----------------------------------------
   // mode timers
   // ----------------------------------------
   localparam int HS_HOLD_W = 8;
   localparam logic [HS_HOLD_W-1:0] HS_HOLD_CYCLES = 77;       // hs hold after request ends

   localparam int LPDT_DONE_W = 10;
   localparam logic [LPDT_DONE_W-1:0] LPDT_DONE_CYCLES = 418;  // one lpdt beat on the wire

   // ----------------------------------------
   // state encodings
   // ----------------------------------------
   typedef enum logic [2:0] {
      hs_awaiting_cmd,
      hs_mode_req,
      hs_short_cmd,
      hs_long_cmd,
      hs_long_data,
      hs_wait_done,
      hs_finish
   } hstx_state_t;

   typedef enum logic [2:0] {
      lp_awaiting_cmd,
      lp_mode_req,
      lp_short_cmd,
      lp_short_rd,
      lp_long_cmd,
      lp_long_data,
      lp_long_rd,
      lp_wait_done
   } lpdt_state_t;

   typedef enum logic [1:0] {
      mode_idle,
      mode_hstx,
      mode_lpdt,
      mode_lpdt_exit
   } dphy_mode_t;

   // long packet data types carry a payload, everything else is short
   function automatic logic is_short_packet(input logic [DATA_TYPE_W-1:0] data_type);
      logic short_flag;
      case (data_type)
         6'h09, 6'h19, 6'h29, 6'h39,
         6'h0C, 6'h1C, 6'h2C,                   // 3C undefined
         6'h0D, 6'h1D, 6'h3D,                   // 2D undefined
         6'h0E, 6'h1E, 6'h0A, 6'h0B,
         6'h2E, 6'h3E: short_flag = 1'b0;
         default:      short_flag = 1'b1;
      endcase
      return short_flag;
   endfunction

endpackage

// File: source/payload_counter.sv
module payload_counter (
   input  logic                                clk_byte,
   input  logic                                reset_byte_n,
   input  logic [pkt_tx_pkg::DATA_TYPE_W-1:0]  tx_cmd_data_type,
   input  logic [pkt_tx_pkg::CMD_COUNT_W-1:0]  tx_cmd_byte_count,
   input  logic                                hs_ack,
   input  logic                                lp_ack,
   input  logic                                hs_payload_en,
   input  logic                                lp_payload_en,
   output logic                                tx_cmd_ack,
   output logic                                tx_payload_en,
   output logic                                tx_payload_en_last,
   output logic                                short_pkt,
   output logic                                cnt_zero,
   output logic                                cnt_final
);

   pkt_tx_pkg::byte_cnt_t byte_cnt;
   logic                  clr_cnt;

   assign tx_cmd_ack         = hs_ack | lp_ack;
   assign tx_payload_en      = hs_payload_en | lp_payload_en;
   assign tx_payload_en_last = tx_payload_en & cnt_final;    // final beat of the packet

   assign short_pkt = pkt_tx_pkg::is_short_packet(tx_cmd_data_type);
   assign cnt_zero  = (byte_cnt == '0);
   assign cnt_final = (byte_cnt <= pkt_tx_pkg::BEAT_BYTES);

   // a last strobe that coincides with a chained ack reloads instead
   assign clr_cnt = (tx_cmd_ack & short_pkt) | (tx_payload_en_last & ~tx_cmd_ack);

   always_ff @(posedge clk_byte or negedge reset_byte_n) begin
      if (!reset_byte_n) begin
         byte_cnt <= '0;
      end else if (clr_cnt) begin
         byte_cnt <= '0;
      end else if (tx_cmd_ack) begin
         byte_cnt <= tx_cmd_byte_count[pkt_tx_pkg::BYTE_CNT_W-1:0];  // upper bits ignored
      end else if (tx_payload_en) begin
         byte_cnt <= byte_cnt - pkt_tx_pkg::BEAT_BYTES;
      end
   end

   // only one sequencer may own the command at a time
   a_single_ack: assert property (@(posedge clk_byte) disable iff (!reset_byte_n)
      !(hs_ack && lp_ack))
      else $error("hs_ack and lp_ack high together");

   // the final strobe always has a word left to count down
   a_last_has_en: assert property (@(posedge clk_byte) disable iff (!reset_byte_n)
      tx_payload_en_last |-> (tx_payload_en && !cnt_zero))
      else $error("tx_payload_en_last with no payload word left");

endmodule

// File: source/hstx_sequencer.sv
module hstx_sequencer (
   input  logic clk_byte,
   input  logic reset_byte_n,
   input  logic tx_cmd_req,
   input  logic tx_hs_mode,
   input  logic hs_active,
   input  logic lp_idle,
   input  logic short_pkt,
   input  logic cnt_zero,
   input  logic cnt_final,
   output logic hs_request,
   output logic hs_ack,
   output logic hs_payload_en,
   output logic hs_idle
);

   pkt_tx_pkg::hstx_state_t state;
   pkt_tx_pkg::hstx_state_t next_state;
   pkt_tx_pkg::hstx_state_t chain_state;

   logic hs_cmd_req;
   logic in_long;
   logic long_done;
   logic mode_go;

   assign hs_cmd_req = tx_cmd_req & tx_hs_mode;
   assign in_long    = (state == pkt_tx_pkg::hs_long_cmd) | (state == pkt_tx_pkg::hs_long_data);
   assign long_done  = in_long & cnt_final;              // final beat or empty packet
   assign mode_go    = hs_active & lp_idle;

   assign hs_idle    = (state == pkt_tx_pkg::hs_awaiting_cmd);
   assign hs_request = (state == pkt_tx_pkg::hs_mode_req) |
                       (state == pkt_tx_pkg::hs_short_cmd) |
                       in_long |
                       (state == pkt_tx_pkg::hs_finish);

   // first ack after the mode comes up, later ones chain inside the mode
   assign hs_ack = ((state == pkt_tx_pkg::hs_mode_req) & mode_go) |
                   (hs_cmd_req & ((state == pkt_tx_pkg::hs_short_cmd) | long_done));

   assign hs_payload_en = in_long & ~cnt_zero;

   // where the next packet starts once acknowledged
   assign chain_state = short_pkt ? pkt_tx_pkg::hs_short_cmd : pkt_tx_pkg::hs_long_cmd;

   always_comb begin
      next_state = state;
      case (state)
         pkt_tx_pkg::hs_awaiting_cmd: begin
            if (hs_cmd_req && lp_idle) next_state = pkt_tx_pkg::hs_mode_req;
         end
         pkt_tx_pkg::hs_mode_req: begin
            if (mode_go) next_state = chain_state;
         end
         pkt_tx_pkg::hs_short_cmd: begin
            if (hs_cmd_req) next_state = chain_state;       // another packet queued
            else if (hs_active) next_state = pkt_tx_pkg::hs_wait_done;
            else next_state = pkt_tx_pkg::hs_awaiting_cmd;
         end
         pkt_tx_pkg::hs_long_cmd,
         pkt_tx_pkg::hs_long_data: begin
            if (!cnt_final) next_state = pkt_tx_pkg::hs_long_data;
            else if (hs_cmd_req) next_state = chain_state;
            else next_state = pkt_tx_pkg::hs_finish;
         end
         pkt_tx_pkg::hs_finish: begin
            if (hs_active) next_state = pkt_tx_pkg::hs_wait_done;
            else next_state = pkt_tx_pkg::hs_awaiting_cmd;
         end
         pkt_tx_pkg::hs_wait_done: begin
            if (!hs_active) next_state = pkt_tx_pkg::hs_awaiting_cmd;  // hold timer expired
         end
         default: next_state = pkt_tx_pkg::hs_awaiting_cmd;
      endcase
   end

   always_ff @(posedge clk_byte or negedge reset_byte_n) begin
      if (!reset_byte_n) begin
         state <= pkt_tx_pkg::hs_awaiting_cmd;
      end else begin
         state <= next_state;
      end
   end

endmodule

// File: source/lpdt_sequencer.sv
module lpdt_sequencer (
   input  logic clk_byte,
   input  logic reset_byte_n,
   input  logic tx_cmd_req,
   input  logic tx_hs_mode,
   input  logic lp_active,
   input  logic lp_done_pulse,
   input  logic hs_idle,
   input  logic short_pkt,
   input  logic cnt_zero,
   output logic lp_request,
   output logic lp_busy_no_rd,
   output logic lp_ack,
   output logic lp_payload_en,
   output logic lp_idle
);

   pkt_tx_pkg::lpdt_state_t state;
   pkt_tx_pkg::lpdt_state_t next_state;
   pkt_tx_pkg::lpdt_state_t done_state;

   logic lp_cmd_req;
   logic buf_wr;
   logic buf_empty;

   assign lp_cmd_req = tx_cmd_req & ~tx_hs_mode;

   // cmd and data states load the lane buffer
   assign buf_wr = (state == pkt_tx_pkg::lp_short_cmd) |
                   (state == pkt_tx_pkg::lp_long_cmd) |
                   (state == pkt_tx_pkg::lp_long_data);

   assign lp_busy_no_rd = buf_wr | (state == pkt_tx_pkg::lp_mode_req);
   assign lp_request    = lp_busy_no_rd |
                          (state == pkt_tx_pkg::lp_short_rd) |
                          (state == pkt_tx_pkg::lp_long_rd);
   assign lp_idle       = (state == pkt_tx_pkg::lp_awaiting_cmd);

   assign lp_ack        = (state == pkt_tx_pkg::lp_mode_req) & lp_active;
   assign lp_payload_en = (state == pkt_tx_pkg::lp_long_rd) & buf_empty & ~cnt_zero;

   // after the final read, take a pending lpdt command or wind down
   assign done_state = lp_cmd_req ? pkt_tx_pkg::lp_mode_req : pkt_tx_pkg::lp_wait_done;

   always_comb begin
      next_state = state;
      case (state)
         pkt_tx_pkg::lp_awaiting_cmd: begin
            if (lp_cmd_req && hs_idle) next_state = pkt_tx_pkg::lp_mode_req;
         end
         pkt_tx_pkg::lp_mode_req: begin
            if (lp_active) begin
               next_state = short_pkt ? pkt_tx_pkg::lp_short_cmd : pkt_tx_pkg::lp_long_cmd;
            end
         end
         pkt_tx_pkg::lp_short_cmd: next_state = pkt_tx_pkg::lp_short_rd;
         pkt_tx_pkg::lp_short_rd: begin
            if (buf_empty) next_state = done_state;
         end
         pkt_tx_pkg::lp_long_cmd,
         pkt_tx_pkg::lp_long_data: next_state = pkt_tx_pkg::lp_long_rd;
         pkt_tx_pkg::lp_long_rd: begin
            if (buf_empty) begin
               next_state = cnt_zero ? done_state : pkt_tx_pkg::lp_long_data;
            end
         end
         pkt_tx_pkg::lp_wait_done: begin
            if (!lp_active) next_state = pkt_tx_pkg::lp_awaiting_cmd;
         end
         default: next_state = pkt_tx_pkg::lp_awaiting_cmd;
      endcase
   end

   always_ff @(posedge clk_byte or negedge reset_byte_n) begin
      if (!reset_byte_n) begin
         state     <= pkt_tx_pkg::lp_awaiting_cmd;
         buf_empty <= 1'b1;
      end else begin
         state <= next_state;
         if (buf_wr) begin
            buf_empty <= 1'b0;
         end else if (lp_done_pulse) begin
            buf_empty <= 1'b1;                 // beat sent on the link
         end
      end
   end

   // a payload read only happens while the link sits in lpdt
   a_rd_in_lpdt: assert property (@(posedge clk_byte) disable iff (!reset_byte_n)
      lp_payload_en |-> lp_active)
      else $error("lp_payload_en outside lpdt mode");

endmodule

// File: source/dphy_mode_ctrl.sv
module dphy_mode_ctrl (
   input  logic clk_byte,
   input  logic reset_byte_n,
   input  logic hs_request,
   input  logic lp_request,
   input  logic lp_busy_no_rd,
   input  logic cnt_zero,
   input  logic tx_hs_mode,
   output logic hs_active,
   output logic lp_active,
   output logic lp_done_pulse,
   output logic tx_active
);

   pkt_tx_pkg::dphy_mode_t mode;

   logic                               hs_req_meta;
   logic                               hs_req_sync;
   logic [pkt_tx_pkg::HS_HOLD_W-1:0]   hold_cnt;
   logic                               hold_done;
   logic [pkt_tx_pkg::LPDT_DONE_W-1:0] done_cnt;
   logic                               lp_done;
   logic                               lp_done_d;
   logic                               cnt_zero_q;
   logic                               lp_request_q;
   logic                               lp_exit_req;

   assign tx_active     = hs_active | lp_active;
   assign lp_done_pulse = lp_done & ~lp_done_d;
   assign lp_exit_req   = hs_req_sync | tx_hs_mode | (~lp_request & ~lp_request_q);

   // ----------------------------------------
   // request sync and history
   // ----------------------------------------
   always_ff @(posedge clk_byte or negedge reset_byte_n) begin
      if (!reset_byte_n) begin
         hs_req_meta  <= 1'b0;
         hs_req_sync  <= 1'b0;
         lp_done_d    <= 1'b0;
         cnt_zero_q   <= 1'b0;
         lp_request_q <= 1'b0;
      end else begin
         hs_req_meta  <= hs_request;
         hs_req_sync  <= hs_req_meta;
         lp_done_d    <= lp_done;
         cnt_zero_q   <= cnt_zero;
         lp_request_q <= lp_request;
      end
   end

   // ----------------------------------------
   // hold and completion timers
   // ----------------------------------------
   always_ff @(posedge clk_byte or negedge reset_byte_n) begin
      if (!reset_byte_n) begin
         hold_cnt  <= '0;
         hold_done <= 1'b0;
      end else if (hs_req_sync) begin
         hold_cnt  <= '0;                      // restart while hs is wanted
         hold_done <= 1'b0;
      end else if (hold_cnt == pkt_tx_pkg::HS_HOLD_CYCLES) begin
         hold_done <= 1'b1;                    // saturate
      end else begin
         hold_cnt  <= hold_cnt + 1'b1;
         hold_done <= 1'b0;
      end
   end

   always_ff @(posedge clk_byte or negedge reset_byte_n) begin
      if (!reset_byte_n) begin
         done_cnt <= '0;
         lp_done  <= 1'b0;
      end else if (lp_busy_no_rd) begin
         done_cnt <= '0;
         lp_done  <= 1'b0;
      end else if (done_cnt == pkt_tx_pkg::LPDT_DONE_CYCLES) begin
         lp_done  <= 1'b1;
      end else begin
         done_cnt <= done_cnt + 1'b1;
         lp_done  <= 1'b0;
      end
   end

   // ----------------------------------------
   // link mode
   // ----------------------------------------
   always_ff @(posedge clk_byte or negedge reset_byte_n) begin
      if (!reset_byte_n) begin
         mode <= pkt_tx_pkg::mode_idle;
      end else begin
         case (mode)
            pkt_tx_pkg::mode_idle: begin
               if (hs_req_sync) mode <= pkt_tx_pkg::mode_hstx;   // hs wins
               else if (lp_request) mode <= pkt_tx_pkg::mode_lpdt;
            end
            pkt_tx_pkg::mode_hstx: begin
               if (hold_done && !hs_req_sync) mode <= pkt_tx_pkg::mode_idle;
            end
            pkt_tx_pkg::mode_lpdt: begin
               if (lp_done_pulse && cnt_zero_q) mode <= pkt_tx_pkg::mode_lpdt_exit;
            end
            pkt_tx_pkg::mode_lpdt_exit: begin
               if (lp_exit_req) mode <= pkt_tx_pkg::mode_idle;
            end
            default: mode <= pkt_tx_pkg::mode_idle;
         endcase
      end
   end

   always_ff @(posedge clk_byte or negedge reset_byte_n) begin
      if (!reset_byte_n) begin
         hs_active <= 1'b0;
         lp_active <= 1'b0;
      end else begin
         hs_active <= (mode == pkt_tx_pkg::mode_hstx);
         lp_active <= (mode == pkt_tx_pkg::mode_lpdt) | (mode == pkt_tx_pkg::mode_lpdt_exit);
      end
   end

   // a mode is only requested once the other one has dropped
   a_one_mode: assert property (@(posedge clk_byte) disable iff (!reset_byte_n)
      !(hs_request && lp_active) && !(lp_request && hs_active))
      else $error("mode requested while the other mode is active");

endmodule

// File: source/packet_tx_top.sv
module packet_tx_top (
   input  logic                                clk_byte,
   input  logic                                reset_byte_n,
   input  logic                                tx_hs_mode,         // 1 hstx, 0 lpdt
   input  logic                                tx_cmd_req,
   input  logic [pkt_tx_pkg::DATA_TYPE_W-1:0]  tx_cmd_data_type,
   input  logic [pkt_tx_pkg::CMD_COUNT_W-1:0]  tx_cmd_byte_count,
   output logic                                tx_cmd_ack,
   output logic                                tx_payload_en,
   output logic                                tx_payload_en_last,
   output logic                                tx_active
);

   logic hs_ack;
   logic hs_payload_en;
   logic hs_request;
   logic hs_idle;
   logic hs_active;

   logic lp_ack;
   logic lp_payload_en;
   logic lp_request;
   logic lp_busy_no_rd;
   logic lp_idle;
   logic lp_active;
   logic lp_done_pulse;

   logic short_pkt;
   logic cnt_zero;
   logic cnt_final;

   // ----------------------------------------
   // packet layer
   // ----------------------------------------
   hstx_sequencer hstx_seq_i (
      .clk_byte      (clk_byte),
      .reset_byte_n  (reset_byte_n),
      .tx_cmd_req    (tx_cmd_req),
      .tx_hs_mode    (tx_hs_mode),
      .hs_active     (hs_active),
      .lp_idle       (lp_idle),
      .short_pkt     (short_pkt),
      .cnt_zero      (cnt_zero),
      .cnt_final     (cnt_final),
      .hs_request    (hs_request),
      .hs_ack        (hs_ack),
      .hs_payload_en (hs_payload_en),
      .hs_idle       (hs_idle)
   );

   lpdt_sequencer lpdt_seq_i (
      .clk_byte      (clk_byte),
      .reset_byte_n  (reset_byte_n),
      .tx_cmd_req    (tx_cmd_req),
      .tx_hs_mode    (tx_hs_mode),
      .lp_active     (lp_active),
      .lp_done_pulse (lp_done_pulse),
      .hs_idle       (hs_idle),
      .short_pkt     (short_pkt),
      .cnt_zero      (cnt_zero),
      .lp_request    (lp_request),
      .lp_busy_no_rd (lp_busy_no_rd),
      .lp_ack        (lp_ack),
      .lp_payload_en (lp_payload_en),
      .lp_idle       (lp_idle)
   );

   payload_counter payload_cnt_i (
      .clk_byte           (clk_byte),
      .reset_byte_n       (reset_byte_n),
      .tx_cmd_data_type   (tx_cmd_data_type),
      .tx_cmd_byte_count  (tx_cmd_byte_count),
      .hs_ack             (hs_ack),
      .lp_ack             (lp_ack),
      .hs_payload_en      (hs_payload_en),
      .lp_payload_en      (lp_payload_en),
      .tx_cmd_ack         (tx_cmd_ack),
      .tx_payload_en      (tx_payload_en),
      .tx_payload_en_last (tx_payload_en_last),
      .short_pkt          (short_pkt),
      .cnt_zero           (cnt_zero),
      .cnt_final          (cnt_final)
   );

   // ----------------------------------------
   // d-phy mode layer
   // ----------------------------------------
   dphy_mode_ctrl dphy_mode_i (
      .clk_byte      (clk_byte),
      .reset_byte_n  (reset_byte_n),
      .hs_request    (hs_request),
      .lp_request    (lp_request),
      .lp_busy_no_rd (lp_busy_no_rd),
      .cnt_zero      (cnt_zero),
      .tx_hs_mode    (tx_hs_mode),
      .hs_active     (hs_active),
      .lp_active     (lp_active),
      .lp_done_pulse (lp_done_pulse),
      .tx_active     (tx_active)
   );

endmodule

// File: test/clock_gen.sv
module clock_gen (
   output logic clk_byte
);

   initial begin
      clk_byte = 1'b0;
   end

   always begin
      #2 clk_byte = ~clk_byte;                 // 4 time unit period
   end

endmodule

// File: test/packet_tx_tb.sv
module packet_tx_tb;

   logic                               clk_byte;
   logic                               reset_byte_n;
   logic                               tx_hs_mode;
   logic                               tx_cmd_req;
   logic [pkt_tx_pkg::DATA_TYPE_W-1:0] tx_cmd_data_type;
   logic [pkt_tx_pkg::CMD_COUNT_W-1:0] tx_cmd_byte_count;
   logic                               tx_cmd_ack;
   logic                               tx_payload_en;
   logic                               tx_payload_en_last;
   logic                               tx_active;

   int     exp_strobes [16];                   // strobes per command, in issue order
   int     pkts_sent;
   int     pkts_opened;
   int     pkts_closed;
   int     pkt_exp;
   int     strobe_cnt;
   logic   pkt_open;
   logic   req_seen;
   logic   in_chain;
   int     value_errors;
   int     other_errors;
   int     hs_n [4];
   int     chain_n [2];
   int     lp_n [2];
   longint limit_time;
   logic   limit_ready;

   clock_gen clk_gen_i (.clk_byte(clk_byte));

   packet_tx_top dut_i (
      .clk_byte           (clk_byte),
      .reset_byte_n       (reset_byte_n),
      .tx_hs_mode         (tx_hs_mode),
      .tx_cmd_req         (tx_cmd_req),
      .tx_cmd_data_type   (tx_cmd_data_type),
      .tx_cmd_byte_count  (tx_cmd_byte_count),
      .tx_cmd_ack         (tx_cmd_ack),
      .tx_payload_en      (tx_payload_en),
      .tx_payload_en_last (tx_payload_en_last),
      .tx_active          (tx_active)
   );

   // ----------------------------------------
   // reference rules
   // ----------------------------------------
   function automatic logic carries_payload(input logic [pkt_tx_pkg::DATA_TYPE_W-1:0] dt);
      logic long_flag;
      case (dt)
         6'h09, 6'h19, 6'h29, 6'h39, 6'h0C, 6'h1C, 6'h2C, 6'h0D,
         6'h1D, 6'h3D, 6'h0E, 6'h1E, 6'h0A, 6'h0B, 6'h2E, 6'h3E: long_flag = 1'b1;
         default: long_flag = 1'b0;
      endcase
      return long_flag;
   endfunction

   function automatic int beats_for(input logic [pkt_tx_pkg::DATA_TYPE_W-1:0] dt, input int n);
      int beats;
      beats = 0;
      if (carries_payload(dt)) beats = (n + 3) / 4;   // one strobe per 4 bytes
      return beats;
   endfunction

   task automatic report_value(input string name, input int got, input int expected);
      value_errors++;
      $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, expected);
   endtask

   task automatic report_problem(input string what);
      other_errors++;
      $display("Error at %0t: %s", $time, what);
   endtask

   task automatic print_counts();
      $display("error counts: %0d wrong values, %0d other failures", value_errors, other_errors);
   endtask

   // ----------------------------------------
   // packet monitor
   // ----------------------------------------
   task automatic close_packet();
      if (strobe_cnt != pkt_exp) report_value("tx_payload_en count", strobe_cnt, pkt_exp);
      pkt_open = 1'b0;
      pkts_closed++;
   endtask

   task automatic open_packet();
      if (pkts_opened >= pkts_sent) begin
         report_problem("ack seen with no command pending");
      end else begin
         pkt_exp = exp_strobes[pkts_opened];
         pkts_opened++;
         strobe_cnt = 0;
         pkt_open = 1'b1;
      end
   endtask

   always @(negedge clk_byte) begin
      if (reset_byte_n) begin
         if (tx_payload_en) strobe_cnt++;       // chained ack strobe belongs to old packet
         if (tx_cmd_ack) begin
            if (pkt_open) close_packet();
            open_packet();
         end else if (pkt_open && !tx_active) begin
            close_packet();
         end
      end
   end

   a_quiet_after_reset: assert property (@(negedge clk_byte)
      !req_seen |-> !(tx_cmd_ack || tx_payload_en || tx_payload_en_last || tx_active))
      else report_value("{ack,en,last,active}",
         int'($sampled({tx_cmd_ack, tx_payload_en, tx_payload_en_last, tx_active})), 0);

   a_last_needs_en: assert property (@(negedge clk_byte) disable iff (!reset_byte_n)
      tx_payload_en_last |-> tx_payload_en)
      else report_value("tx_payload_en", int'($sampled(tx_payload_en)), 1);

   a_last_on_final: assert property (@(negedge clk_byte) disable iff (!reset_byte_n)
      tx_payload_en |-> (tx_payload_en_last == (strobe_cnt + 1 == pkt_exp)))
      else report_value("tx_payload_en_last", int'($sampled(tx_payload_en_last)),
         int'($sampled(strobe_cnt) + 1 == $sampled(pkt_exp)));

   a_strobe_in_packet: assert property (@(negedge clk_byte) disable iff (!reset_byte_n)
      tx_payload_en |-> (pkt_open && strobe_cnt < pkt_exp))
      else report_problem("payload strobe outside a packet or beyond its beat count");

   a_chain_on_last: assert property (@(negedge clk_byte) disable iff (!reset_byte_n)
      (tx_cmd_ack && pkt_open && pkt_exp != 0) |-> tx_payload_en_last)
      else report_value("tx_payload_en_last at chained ack",
         int'($sampled(tx_payload_en_last)), 1);

   a_active_on_xfer: assert property (@(negedge clk_byte) disable iff (!reset_byte_n)
      (tx_cmd_ack || tx_payload_en) |-> tx_active)
      else report_value("tx_active", int'($sampled(tx_active)), 1);

   a_active_in_chain: assert property (@(negedge clk_byte) disable iff (!reset_byte_n)
      in_chain |-> tx_active)
      else report_value("tx_active between chained packets", int'($sampled(tx_active)), 1);

   // ----------------------------------------
   // stimulus
   // ----------------------------------------
   task automatic queue_cmd(input logic [pkt_tx_pkg::DATA_TYPE_W-1:0] dt, input int n);
      exp_strobes[pkts_sent] = beats_for(dt, n);
      pkts_sent++;
   endtask

   task automatic drive_cmd(input logic hs, input logic [pkt_tx_pkg::DATA_TYPE_W-1:0] dt,
                            input int n);
      tx_hs_mode        = hs;
      tx_cmd_data_type  = dt;
      tx_cmd_byte_count = 16'(n);
      tx_cmd_req        = 1'b1;
      req_seen          = 1'b1;
   endtask

   task automatic wait_ack();
      do @(negedge clk_byte); while (!tx_cmd_ack);
      @(posedge clk_byte);
      #1;
   endtask

   task automatic wait_link_idle();
      do @(negedge clk_byte); while (tx_active);
      repeat (4) @(posedge clk_byte);          // let the sequencers settle back
      #1;
   endtask

   task automatic send_cmd(input logic hs, input logic [pkt_tx_pkg::DATA_TYPE_W-1:0] dt,
                           input int n);
      queue_cmd(dt, n);
      drive_cmd(hs, dt, n);
      wait_ack();
      tx_cmd_req = 1'b0;
      wait_link_idle();
   endtask

   task automatic send_chain(input logic [pkt_tx_pkg::DATA_TYPE_W-1:0] dt, input int n_first,
                             input int n_second);
      queue_cmd(dt, n_first);
      queue_cmd(dt, n_second);
      drive_cmd(1'b1, dt, n_first);
      wait_ack();
      tx_cmd_byte_count = 16'(n_second);       // second packet queued behind the first
      in_chain = 1'b1;
      wait_ack();
      tx_cmd_req = 1'b0;
      in_chain = 1'b0;
      wait_link_idle();
   endtask

   task automatic plan_watchdog();
      int lp_beats;
      int hs_pkts;
      lp_beats = 1;                            // lpdt short packet
      foreach (lp_n[i]) lp_beats += (lp_n[i] + 3) / 4 + 1;
      hs_pkts = 7;
      limit_time = longint'(lp_beats * (int'(pkt_tx_pkg::LPDT_DONE_CYCLES) + 20) +
                            hs_pkts * (int'(pkt_tx_pkg::HS_HOLD_CYCLES) + 100)) * 2 * 4;
      limit_ready = 1'b1;
   endtask

   initial begin
      wait (limit_ready);
      #(limit_time);
      $display("Error at %0t: watchdog expired before the tests finished", $time);
      print_counts();
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      reset_byte_n = 1'b0;
      tx_hs_mode = 1'b0;
      tx_cmd_req = 1'b0;
      tx_cmd_data_type = '0;
      tx_cmd_byte_count = '0;
      pkts_sent = 0;
      pkts_opened = 0;
      pkts_closed = 0;
      pkt_exp = 0;
      strobe_cnt = 0;
      pkt_open = 1'b0;
      req_seen = 1'b0;
      in_chain = 1'b0;
      value_errors = 0;
      other_errors = 0;
      limit_ready = 1'b0;
      void'($urandom(32'h1dbb18df));
      foreach (hs_n[i]) hs_n[i] = int'($urandom_range(64, 1));
      foreach (chain_n[i]) chain_n[i] = int'($urandom_range(64, 1));
      foreach (lp_n[i]) lp_n[i] = int'($urandom_range(12, 1));
      plan_watchdog();
      repeat (3) @(posedge clk_byte);
      #1;
      reset_byte_n = 1'b1;
      repeat (20) @(posedge clk_byte);         // outputs must stay quiet meanwhile
      #1;
      send_cmd(1'b1, 6'h2C, hs_n[0]);
      send_cmd(1'b1, 6'h1E, hs_n[1]);
      send_cmd(1'b1, 6'h0A, hs_n[2]);
      send_cmd(1'b1, 6'h3E, hs_n[3]);
      send_cmd(1'b1, 6'h3C, 2);                // 3C sits next to long types but is short
      send_chain(6'h29, chain_n[0], chain_n[1]);
      send_cmd(1'b0, 6'h05, 1);
      send_cmd(1'b0, 6'h2E, lp_n[0]);
      send_cmd(1'b0, 6'h19, lp_n[1]);
      if (pkt_open) report_problem("last packet never completed");
      if (pkts_closed != pkts_sent) report_value("packets completed", pkts_closed, pkts_sent);
      print_counts();
      if (value_errors == 0 && other_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: verilog.f
source/pkt_tx_pkg.sv
source/payload_counter.sv
source/hstx_sequencer.sv
source/lpdt_sequencer.sv
source/dphy_mode_ctrl.sv
source/packet_tx_top.sv
test/clock_gen.sv
test/packet_tx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module packet_tx_tb \
   -f verilog.f -o packet_tx_sim

output=$(./obj_dir/packet_tx_sim)
echo "$output"

if ! echo "$output" | grep -qF '*** TEST PASSED ***'; then
   exit 1
fi
exit 0
